//--- hdl/fe_settings.svh
// build settings for the fetch front end
// the line size is fixed at two 32-bit instructions (8 bytes)
// only FE_IBUF_DEPTH may be changed, any value of 1 or more
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// ============================================================
// addresses and instructions
// ============================================================
`define FE_VADDR_W    32            // virtual byte address
`define FE_INST_W     32            // one RV32 instruction

// ============================================================
// memory line
// ============================================================
`define FE_LINE_INSTS 2             // instructions per line
`define FE_LINE_BYTES 8             // keep equal to insts * 4

// reset vector, must be 4-byte aligned
`define FE_PC_RESET   32'h0000_1000

// lines held by the instruction buffer
`define FE_IBUF_DEPTH 2

`endif

//--- hdl/fe_pkg.sv
// shared types of the fetch front end
// trap kinds carry their RISC-V cause code, so the code also
// indexes medeleg; non-trap flush kinds sit at 16 and up
`include "fe_settings.svh"

package fe_pkg;

  typedef logic [`FE_VADDR_W-1:0]                 vaddr_t;
  typedef logic [`FE_INST_W-1:0]                  inst_t;
  typedef logic [`FE_LINE_INSTS*`FE_INST_W-1:0]   line_t;   // lowest address in low bits
  typedef logic [$clog2(`FE_LINE_INSTS)-1:0]      slot_t;   // instruction index in a line

  // flush kinds reported by the committer
  typedef enum logic [4:0] {
    INST_ACC_FAULT = 5'd1,
    ILLEGAL_INST   = 5'd2,
    ECALL_U        = 5'd8,
    ECALL_S        = 5'd9,
    ECALL_M        = 5'd11,
    SILENT_FLUSH   = 5'd16,
    ANOTHER_FLUSH  = 5'd17,
    MRET           = 5'd18,
    SRET           = 5'd19
  } except_t;

  typedef struct packed {
    logic    valid;
    except_t kind;
    vaddr_t  epc;
  } commit_t;

  typedef struct packed {
    logic   valid;
    logic   mispredict;
    vaddr_t target;
  } br_upd_t;

  typedef struct packed {
    vaddr_t      mtvec;
    vaddr_t      stvec;
    vaddr_t      mepc;
    vaddr_t      sepc;
    logic [15:0] medeleg;   // one bit per exception cause
  } csr_info_t;

  typedef struct packed {
    logic   valid;
    vaddr_t target;
  } redirect_t;

  typedef struct packed {
    vaddr_t addr;    // line aligned
    slot_t  slot;    // first slot to hand out
    line_t  data;
  } fetch_line_t;

  typedef struct packed {
    vaddr_t pc;
    inst_t  inst;
  } disp_inst_t;

  typedef enum logic [2:0] {
    INIT,
    FETCH_REQ,
    WAIT_ACK,
    WAIT_ACK_LOW,
    WAIT_IBUF_FREE
  } fetch_state_t;

endpackage

//--- hdl/fe_redirect.sv
// redirect target selection, purely combinational
// a committed flush wins over a branch mispredict in the same cycle
// trap kinds are delegated to S-mode by the medeleg bit at their cause

module fe_redirect (
  input  fe_pkg::commit_t   i_commit,
  input  fe_pkg::br_upd_t   i_br_upd,
  input  fe_pkg::csr_info_t i_csr,
  output fe_pkg::redirect_t o_redirect
);

  import fe_pkg::*;

  logic   w_br_flush;
  logic   w_delegated;
  vaddr_t w_trap_vec;
  vaddr_t w_commit_target;

  assign w_br_flush = i_br_upd.valid & i_br_upd.mispredict;

  // trap cause codes are all below 16, low four bits pick the medeleg bit
  assign w_delegated = i_csr.medeleg[i_commit.kind[3:0]];
  assign w_trap_vec  = w_delegated ? i_csr.stvec : i_csr.mtvec;

  // ============================================================
  // commit target by flush kind
  // ============================================================
  always_comb begin
    case (i_commit.kind)
      SILENT_FLUSH:  w_commit_target = i_commit.epc + vaddr_t'(4);  // resume after it
      ANOTHER_FLUSH: w_commit_target = i_commit.epc;                // replay it
      MRET:          w_commit_target = i_csr.mepc;
      SRET:          w_commit_target = i_csr.sepc;
      INST_ACC_FAULT,
      ILLEGAL_INST,
      ECALL_U,
      ECALL_S,
      ECALL_M:       w_commit_target = w_trap_vec;
      default:       w_commit_target = i_csr.mtvec;  // unknown kind, take M-mode trap
    endcase
  end

  // commit first, then branch
  always_comb begin
    o_redirect.valid  = i_commit.valid | w_br_flush;
    o_redirect.target = i_commit.valid ? w_commit_target : i_br_upd.target;
  end

endmodule

//--- hdl/fe_fetch_ctrl.sv
// fetch FSM with PC register and four-phase memory requester
// one request in flight at most; the address is held in its own
// register so a redirect never moves it while req is high
// a line fetched before a redirect is finished and thrown away
`include "fe_settings.svh"

module fe_fetch_ctrl (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  fe_pkg::redirect_t   i_redirect,
  input  logic                i_ibuf_free,
  output logic                o_mem_req,
  output fe_pkg::vaddr_t      o_mem_addr,
  input  logic                i_mem_ack,
  input  fe_pkg::line_t       i_mem_data,
  output logic                o_line_load,
  output fe_pkg::fetch_line_t o_line
);

  import fe_pkg::*;

  localparam int LINE_OFS = $clog2(`FE_LINE_BYTES);
  localparam int INST_OFS = $clog2(`FE_INST_W / 8);

  fetch_state_t r_state;
  fetch_state_t w_state_next;
  vaddr_t       r_pc;
  vaddr_t       w_pc_next;
  vaddr_t       w_pc_line;
  vaddr_t       r_req_addr;
  logic         r_stale;
  logic         w_stale_next;
  logic         w_issue;

  assign w_pc_line = {r_pc[`FE_VADDR_W-1:LINE_OFS], {LINE_OFS{1'b0}}};

  // capture on first ack, unless the request belongs to an old path
  assign o_line_load = (r_state == WAIT_ACK) & i_mem_ack & ~r_stale & ~i_redirect.valid;

  // ============================================================
  // next state and PC
  // ============================================================
  always_comb begin
    w_state_next = r_state;
    w_pc_next    = r_pc;
    w_stale_next = r_stale;
    w_issue      = 1'b0;

    case (r_state)
      INIT: begin
        w_state_next = FETCH_REQ;
      end
      FETCH_REQ, WAIT_IBUF_FREE: begin
        if (i_redirect.valid) begin
          w_state_next = FETCH_REQ;  // buffer is emptied, retry next cycle
        end else if (i_ibuf_free) begin
          w_issue      = 1'b1;
          w_state_next = WAIT_ACK;
        end else begin
          w_state_next = WAIT_IBUF_FREE;
        end
      end
      WAIT_ACK: begin
        if (i_redirect.valid) begin
          w_stale_next = 1'b1;
        end
        if (i_mem_ack) begin
          w_state_next = WAIT_ACK_LOW;
          if (o_line_load) begin
            w_pc_next = r_req_addr + vaddr_t'(`FE_LINE_BYTES);  // sequential line
          end
        end
      end
      WAIT_ACK_LOW: begin
        if (i_redirect.valid) begin
          w_stale_next = 1'b1;
        end
        if (!i_mem_ack) begin
          w_state_next = FETCH_REQ;
          w_stale_next = 1'b0;    // handshake idle again
        end
      end
      default: begin
        w_state_next = INIT;
      end
    endcase

    // a redirect always wins the PC
    if (i_redirect.valid) begin
      w_pc_next = i_redirect.target;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
      r_pc    <= vaddr_t'(`FE_PC_RESET);
      r_stale <= 1'b0;
    end else begin
      r_state <= w_state_next;
      r_pc    <= w_pc_next;
      r_stale <= w_stale_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_issue) begin
      r_req_addr <= w_pc_line;
    end
  end

  // ============================================================
  // memory port and line out
  // ============================================================
  assign o_mem_req  = (r_state == WAIT_ACK);
  assign o_mem_addr = r_req_addr;

  always_comb begin
    o_line.addr = r_req_addr;
    o_line.slot = r_pc[LINE_OFS-1:INST_OFS];  // pc still points into this line
    o_line.data = i_mem_data;
  end

endmodule

//--- hdl/fe_inst_buffer.sv
// line FIFO feeding dispatch one instruction at a time
// the head entry's slot field doubles as the slot pointer and is
// advanced in place; a line is popped after its last slot goes out
// the writer must only load while o_free is high
`include "fe_settings.svh"

module fe_inst_buffer (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_flush,
  input  logic                i_line_load,
  input  fe_pkg::fetch_line_t i_line,
  output logic                o_free,
  output logic                o_disp_valid,
  output fe_pkg::disp_inst_t  o_disp,
  input  logic                i_disp_ready
);

  import fe_pkg::*;

  localparam int DEPTH    = `FE_IBUF_DEPTH;
  localparam int PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W    = $clog2(DEPTH + 1);
  localparam int LINE_OFS = $clog2(`FE_LINE_BYTES);
  localparam int INST_OFS = $clog2(`FE_INST_W / 8);

  fetch_line_t      r_lines [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  fetch_line_t      w_head;
  logic             w_load;
  logic             w_pop_inst;
  logic             w_last_slot;
  logic             w_pop_line;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign w_head      = r_lines[r_rd_ptr];
  assign w_load      = i_line_load & ~i_flush;
  assign w_pop_inst  = o_disp_valid & i_disp_ready;
  assign w_last_slot = (w_head.slot == slot_t'(`FE_LINE_INSTS - 1));
  assign w_pop_line  = w_pop_inst & w_last_slot;

  // ============================================================
  // pointers and occupancy
  // ============================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else if (i_flush) begin
      r_wr_ptr <= '0;  // whole buffer dropped on redirect
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_load) begin
        r_wr_ptr <= ptr_inc(r_wr_ptr);
      end
      if (w_pop_line) begin
        r_rd_ptr <= ptr_inc(r_rd_ptr);
      end
      r_count <= r_count + CNT_W'(w_load) - CNT_W'(w_pop_line);
    end
  end

  // write and head slot update never hit the same entry
  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_lines[r_wr_ptr] <= i_line;
    end
    if (w_pop_inst && !w_last_slot) begin
      r_lines[r_rd_ptr].slot <= w_head.slot + 1'b1;
    end
  end

  assign o_free       = (r_count != CNT_W'(DEPTH));
  assign o_disp_valid = (r_count != '0);

  always_comb begin
    o_disp.pc   = {w_head.addr[`FE_VADDR_W-1:LINE_OFS], w_head.slot, {INST_OFS{1'b0}}};
    o_disp.inst = w_head.data[w_head.slot*`FE_INST_W +: `FE_INST_W];
  end

endmodule

//--- hdl/fe_frontend.sv
// fetch front end top, wiring only
// every redirect flushes the buffer and restarts fetch at its target

module fe_frontend (
  input  logic               i_clk,
  input  logic               i_reset_n,

  // commit, branch resolution and trap CSRs
  input  fe_pkg::commit_t    i_commit,
  input  fe_pkg::br_upd_t    i_br_upd,
  input  fe_pkg::csr_info_t  i_csr,

  // instruction memory, four-phase req/ack
  output logic               o_mem_req,
  output fe_pkg::vaddr_t     o_mem_addr,
  input  logic               i_mem_ack,
  input  fe_pkg::line_t      i_mem_data,

  // dispatch, valid/ready
  output logic               o_disp_valid,
  output fe_pkg::disp_inst_t o_disp,
  input  logic               i_disp_ready
);

  import fe_pkg::*;

  redirect_t   w_redirect;
  logic        w_line_load;
  fetch_line_t w_line;
  logic        w_ibuf_free;

  fe_redirect fe_redirect_i (
    .i_commit   (i_commit),
    .i_br_upd   (i_br_upd),
    .i_csr      (i_csr),
    .o_redirect (w_redirect)
  );

  fe_fetch_ctrl fe_fetch_ctrl_i (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_redirect  (w_redirect),
    .i_ibuf_free (w_ibuf_free),
    .o_mem_req   (o_mem_req),
    .o_mem_addr  (o_mem_addr),
    .i_mem_ack   (i_mem_ack),
    .i_mem_data  (i_mem_data),
    .o_line_load (w_line_load),
    .o_line      (w_line)
  );

  fe_inst_buffer fe_inst_buffer_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (w_redirect.valid),
    .i_line_load  (w_line_load),
    .i_line       (w_line),
    .o_free       (w_ibuf_free),
    .o_disp_valid (o_disp_valid),
    .o_disp       (o_disp),
    .i_disp_ready (i_disp_ready)
  );

endmodule

//--- tb/tb_clock.sv
// clock and reset source for the front end testbench
// 40 ns period, reset low until 2 ns after the 8th rising edge

module tb_clock (
  output logic o_clk,
  output logic o_reset_n
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES = 8;

  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk;  // 40 ns period
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #2 o_reset_n = 1'b1;  // released with the other inputs
  end

endmodule

//--- tb/tb_frontend.sv
// testbench for the fetch front end
// memory word at byte address a is a ^ A5A5_0000
// ack follows req up and down after 0 to 5 cycles unless a test pins the delay
// inputs change 2 ns after the rising edge and checks run on the falling edge
// the first failing check ends the run
`include "fe_settings.svh"

module tb_frontend;

  timeunit 1ns;
  timeprecision 100ps;

  import fe_pkg::*;

  localparam int          WAIT_LIMIT = 400;  // cycles per wait
  localparam int          MIN_XFERS  = 120;
  localparam logic [31:0] INST_KEY   = 32'hA5A5_0000;

  logic       i_clk;
  logic       i_reset_n;
  commit_t    i_commit;
  br_upd_t    i_br_upd;
  csr_info_t  i_csr;
  logic       o_mem_req;
  vaddr_t     o_mem_addr;
  logic       i_mem_ack;
  line_t      i_mem_data;
  logic       o_disp_valid;
  disp_inst_t o_disp;
  logic       i_disp_ready;

  // stimulus modes written 1 ns after the rising edge
  int unsigned ack_min;
  int unsigned ack_max;
  logic        ready_random;
  logic        ready_level;

  // memory responder
  logic        mem_req_seen;
  vaddr_t      mem_addr_seen;
  logic        delay_armed;
  int unsigned delay_left;

  // reference model and last falling edge samples
  vaddr_t     exp_pc;
  int         xfer_count;
  logic       redirect_now;
  logic       prev_req;
  logic       prev_ack;
  vaddr_t     prev_addr;
  logic       prev_valid;
  logic       prev_ready;
  logic       prev_redirect;
  disp_inst_t prev_disp;

  tb_clock tb_clock_i (
    .o_clk     (i_clk),
    .o_reset_n (i_reset_n)
  );

  fe_frontend fe_frontend_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_commit     (i_commit),
    .i_br_upd     (i_br_upd),
    .i_csr        (i_csr),
    .o_mem_req    (o_mem_req),
    .o_mem_addr   (o_mem_addr),
    .i_mem_ack    (i_mem_ack),
    .i_mem_data   (i_mem_data),
    .o_disp_valid (o_disp_valid),
    .o_disp       (o_disp),
    .i_disp_ready (i_disp_ready)
  );

  // ============================================================
  // helpers
  // ============================================================
  function automatic line_t line_data(input vaddr_t addr);
    return {(addr + 32'd4) ^ INST_KEY, addr ^ INST_KEY};  // low word at low address
  endfunction

  // where fetch must restart for the given inputs
  function automatic vaddr_t redirect_target(input commit_t c, input br_upd_t b,
                                             input csr_info_t csr);
    int code;
    code = int'(c.kind);
    if (!c.valid)
      return b.target;
    if (c.kind == SILENT_FLUSH)
      return c.epc + 32'd4;
    if (c.kind == ANOTHER_FLUSH)
      return c.epc;
    if (c.kind == MRET)
      return csr.mepc;
    if (c.kind == SRET)
      return csr.sepc;
    if (code < 16 && csr.medeleg[code[3:0]])
      return csr.stvec;  // delegated trap
    return csr.mtvec;
  endfunction

  function automatic commit_t make_commit(input except_t kind, input vaddr_t epc);
    commit_t c;
    c       = '0;
    c.valid = 1'b1;
    c.kind  = kind;
    c.epc   = epc;
    return c;
  endfunction

  function automatic br_upd_t make_branch(input vaddr_t target);
    br_upd_t b;
    b            = '0;
    b.valid      = 1'b1;
    b.mispredict = 1'b1;
    b.target     = target;
    return b;
  endfunction

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic print_mismatch(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
    $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    abort_run();
  endtask

  task automatic report_problem(input string what);
    $display("ERROR time=%0t %s", $time, what);
    abort_run();
  endtask

  task automatic set_ready_mode(input logic rnd, input logic level);
    @(posedge i_clk);
    #1;
    ready_random = rnd;
    ready_level  = level;
  endtask

  task automatic set_ack_delay(input int unsigned lo, input int unsigned hi);
    @(posedge i_clk);
    #1;
    ack_min = lo;
    ack_max = hi;
  endtask

  // one cycle pulse on the commit and branch ports
  task automatic drive_redirect(input commit_t c, input br_upd_t b, input csr_info_t csr);
    @(posedge i_clk);
    #2;
    i_commit = c;
    i_br_upd = b;
    i_csr    = csr;
    @(posedge i_clk);
    #2;
    i_commit = '0;
    i_br_upd = '0;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (!i_reset_n) begin
      @(negedge i_clk);
      cycles++;
      if (cycles > 20)
        report_problem("reset never released");
    end
  endtask

  task automatic wait_transfers(input int n, input string what);
    int start;
    int cycles;
    start  = xfer_count;
    cycles = 0;
    while (xfer_count < start + n) begin
      @(posedge i_clk);
      cycles++;
      if (cycles > WAIT_LIMIT)
        report_problem({"timeout waiting for dispatch after ", what});
    end
  endtask

  // stops at a falling edge where a request waits for its ack
  task automatic wait_req_pending();
    int cycles;
    cycles = 0;
    do begin
      @(negedge i_clk);
      cycles++;
      if (cycles > WAIT_LIMIT)
        report_problem("timeout waiting for a pending memory request");
    end while (!(o_mem_req && !i_mem_ack));
  endtask

  // ack still high after req has dropped
  task automatic wait_ack_drop_phase();
    int cycles;
    cycles = 0;
    do begin
      @(negedge i_clk);
      cycles++;
      if (cycles > WAIT_LIMIT)
        report_problem("timeout waiting for ack high with req low");
    end while (!(i_mem_ack && !o_mem_req));
  endtask

  // ============================================================
  // memory responder and ready driver
  // ============================================================
  always @(negedge i_clk) begin
    mem_req_seen  = o_mem_req;
    mem_addr_seen = o_mem_addr;
  end

  always @(posedge i_clk) begin
    #2;
    if (ready_random) begin
      i_disp_ready = ($urandom_range(1, 0) == 1);
    end else begin
      i_disp_ready = ready_level;
    end

    // ack follows req up and down after its own random delay
    if (i_mem_ack != mem_req_seen) begin
      if (!delay_armed) begin
        delay_left  = $urandom_range(ack_max, ack_min);
        delay_armed = 1'b1;
      end
      if (delay_left == 0) begin
        i_mem_ack   = mem_req_seen;
        i_mem_data  = line_data(mem_addr_seen);
        delay_armed = 1'b0;
      end else begin
        delay_left--;
      end
    end
  end

  // ============================================================
  // checks and reference model
  // ============================================================
  always @(negedge i_clk) begin
    if (!i_reset_n) begin
      assert (!o_mem_req && !o_disp_valid)
        else report_problem("o_mem_req or o_disp_valid high during reset");
      exp_pc        = `FE_PC_RESET;
      xfer_count    = 0;
      prev_req      = 1'b0;
      prev_ack      = 1'b0;
      prev_valid    = 1'b0;
      prev_ready    = 1'b0;
      prev_redirect = 1'b0;
    end else begin
      redirect_now = i_commit.valid || (i_br_upd.valid && i_br_upd.mispredict);

      // four-phase rules
      if (prev_req && !prev_ack) begin
        assert (o_mem_req) else report_problem("o_mem_req dropped before i_mem_ack");
      end
      if (o_mem_req && !prev_req) begin
        assert (!prev_ack) else report_problem("o_mem_req raised while i_mem_ack high");
      end
      if (o_mem_req && prev_req) begin
        assert (o_mem_addr == prev_addr)
          else print_mismatch("o_mem_addr", prev_addr, o_mem_addr);
      end
      if (o_mem_req) begin
        assert (o_mem_addr[2:0] == 3'b000) else report_problem("o_mem_addr not line aligned");
      end

      // dispatch port
      if (prev_redirect) begin
        assert (!o_disp_valid) else report_problem("o_disp_valid high after a redirect");
      end else if (prev_valid && !prev_ready) begin
        assert (o_disp_valid) else report_problem("o_disp_valid dropped while stalled");
        assert (o_disp == prev_disp) else print_mismatch("o_disp", prev_disp, o_disp);
      end

      if (redirect_now) begin
        exp_pc = redirect_target(i_commit, i_br_upd, i_csr);
      end else if (o_disp_valid && i_disp_ready) begin
        assert (o_disp.pc == exp_pc) else print_mismatch("o_disp.pc", exp_pc, o_disp.pc);
        assert (o_disp.inst == (exp_pc ^ INST_KEY))
          else print_mismatch("o_disp.inst", exp_pc ^ INST_KEY, o_disp.inst);
        exp_pc = exp_pc + 32'd4;
        xfer_count++;
      end

      prev_req      = o_mem_req;
      prev_ack      = i_mem_ack;
      prev_addr     = o_mem_addr;
      prev_valid    = o_disp_valid;
      prev_ready    = i_disp_ready;
      prev_redirect = redirect_now;
      prev_disp     = o_disp;
    end
  end

  // ============================================================
  // stimulus
  // ============================================================
  initial begin
    except_t     kinds [9];
    csr_info_t   csr;
    vaddr_t      base;
    logic [15:0] mask;
    int          code;
    int          k;
    int          d;

    void'($urandom(57));
    kinds = '{INST_ACC_FAULT, ILLEGAL_INST, ECALL_U, ECALL_S, ECALL_M,
              SILENT_FLUSH, ANOTHER_FLUSH, MRET, SRET};
    i_commit      = '0;
    i_br_upd      = '0;
    i_csr         = '0;
    i_mem_ack     = 1'b0;
    i_mem_data    = '0;
    i_disp_ready  = 1'b0;
    ready_random  = 1'b0;
    ready_level   = 1'b1;
    ack_min       = 0;
    ack_max       = 5;
    mem_req_seen  = 1'b0;
    delay_armed   = 1'b0;
    delay_left    = 0;
    csr           = '0;

    wait_reset_release();

    // straight line fetch from the reset vector
    wait_transfers(8, "reset");

    // hold dispatch off until the buffer is full and then apply random back-pressure
    set_ready_mode(1'b0, 1'b0);
    repeat (40) @(posedge i_clk);
    set_ready_mode(1'b1, 1'b0);
    wait_transfers(40, "random ready");
    set_ready_mode(1'b0, 1'b1);

    // mispredict into the second slot of a line
    drive_redirect('0, make_branch(32'h0000_8004), csr);
    wait_transfers(6, "branch mispredict");

    // every commit kind with its medeleg bit clear then set
    for (k = 0; k < 9; k++) begin
      for (d = 0; d < 2; d++) begin
        base        = 32'h0001_0000 + vaddr_t'(k * 32'h200 + d * 32'h100);
        code        = int'(kinds[k]);
        mask        = (code < 16) ? 16'(1 << code) : 16'hFFFF;
        csr.mtvec   = base;
        csr.stvec   = base + 32'h14;
        csr.mepc    = base + 32'h28;
        csr.sepc    = base + 32'h34;
        csr.medeleg = (d == 1) ? mask : ~mask;  // other bits opposite
        drive_redirect(make_commit(kinds[k], base + 32'h44), '0, csr);
        wait_transfers(3, "commit flush");
      end
    end

    // commit and mispredict together
    drive_redirect(make_commit(SRET, 32'h0002_F000), make_branch(32'h0003_0000), csr);
    wait_transfers(3, "commit with branch");
    drive_redirect(make_commit(ECALL_S, 32'h0002_F100), make_branch(32'h0003_0100), csr);
    wait_transfers(3, "trap with branch");

    // redirects while a memory handshake is open
    set_ack_delay(4, 4);
    for (k = 0; k < 4; k++) begin
      wait_req_pending();
      drive_redirect('0, make_branch(32'h0004_0000 + vaddr_t'(k * 32'h104)), csr);
      wait_transfers(4, "redirect during WAIT_ACK");
    end
    wait_ack_drop_phase();
    drive_redirect('0, make_branch(32'h0005_000C), csr);
    wait_transfers(4, "redirect during WAIT_ACK_LOW");
    set_ack_delay(0, 5);
    wait_transfers(4, "random ack delay");

    if (xfer_count < MIN_XFERS) begin
      report_problem("too few instructions were dispatched");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

//--- sim.f
+incdir+hdl
hdl/fe_pkg.sv
hdl/fe_redirect.sv
hdl/fe_fetch_ctrl.sv
hdl/fe_inst_buffer.sv
hdl/fe_frontend.sv
tb/tb_clock.sv
tb/tb_frontend.sv

//--- run.sh
#!/usr/bin/env bash
# build the front end testbench with Verilator and run it
# exit status is non-zero when the simulation stops on an error
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_frontend -f sim.f -o tb_frontend_sim

./obj_dir/tb_frontend_sim
